/* testbench/tx_input.txt */
// Packet list: mode pid count payload[count] crc_lo crc_hi
// Mode 00 normal, 01 pin flip, 02 oscillator test, 03 link reset, ff ends the list
00 09 00 00 00
00 03 09 31 32 33 34 35 36 37 38 39 c8 b4
00 0b 00 00 00
00 03 01 00 40 bf
00 03 03 ff ff ff bf bf
00 0b 02 ff ff ff ff
01 07 09 31 32 33 34 35 36 37 38 39 c8 b4
01 02 00 00 00
02 00 00 00 00
03 03 10 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 00 00
00 0b 01 00 40 bf
00 0d 00 00 00
ff

/* all.f */
verilog/usb_pkg.sv
verilog/usb_tx_cfg_pkg.sv
verilog/usb_bit_timer.sv
verilog/usb_tx_fifo.sv
verilog/usb_fs_tx.sv
verilog/usb_tx_top.sv
testbench/usb_tx_properties.sv
testbench/tb_usb_tx.sv

/* Bender.yml */
package:
  name: usb_tx

sources:
  # Packages
  - verilog/usb_pkg.sv
  - verilog/usb_tx_cfg_pkg.sv
  # RTL
  - verilog/usb_bit_timer.sv
  - verilog/usb_tx_fifo.sv
  - verilog/usb_fs_tx.sv
  - verilog/usb_tx_top.sv
  # Testbench
  - target: test
    files:
      - testbench/usb_tx_properties.sv
      - testbench/tb_usb_tx.sv

/* testbench/tb_usb_tx.sv */
/*
  Testbench of the USB transmit subsystem: clock and reset, packets
  read from a data file, line sampling with NRZI decoding and checks
*/
`timescale 1ns/100ps

module tb_usb_tx
  import usb_pkg::*;
  import usb_tx_cfg_pkg::*;
();

  localparam int unsigned OSC_BITS = 24;
  localparam int unsigned MEM_SIZE = 256;
  localparam int unsigned MARGIN   = 2000;
  localparam logic [7:0]  MODE_FLIP  = 8'h01;
  localparam logic [7:0]  MODE_OSC   = 8'h02;
  localparam logic [7:0]  MODE_LINK  = 8'h03;
  localparam logic [7:0]  LIST_END   = 8'hFF;
  localparam logic [1:0]  SYM_K      = 2'd0;
  localparam logic [1:0]  SYM_J      = 2'd1;
  localparam logic [1:0]  SYM_SE0    = 2'd2;
  // KJKJKJKK on the wire, seven zeros then a one
  localparam usb_byte_t   SYNC_PATTERN  = 8'h80;
  // Low PID bits of DATA0, DATA1, DATA2 and MDATA
  localparam logic [1:0]  DATA_PID_BITS = 2'b11;

  logic        clk_i;
  logic        rst_ni;
  logic        link_reset_i;
  logic        cfg_pinflip_i;
  logic        osc_test_i;
  logic        wr_valid_i;
  usb_byte_t   wr_data_i;
  logic        pkt_start_i;
  usb_pid_t    pid_i;
  logic        wr_full_o;
  logic        pkt_end_o;
  usb_line_t   line_o;

  usb_byte_t   stim_mem [MEM_SIZE];
  logic [1:0]  symbols [$];
  usb_byte_t   got_bytes [$];
  int          errors = 0;
  int          checks = 0;
  int          end_pulses = 0;
  int          seed = 32'h8c60_b7c7;
  int unsigned cycles = 0;
  int unsigned cycle_limit = 32'hFFFF_FFFF;

  usb_tx_top i_usb_tx_top (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .link_reset_i  (link_reset_i),
    .cfg_pinflip_i (cfg_pinflip_i),
    .osc_test_i    (osc_test_i),
    .wr_valid_i    (wr_valid_i),
    .wr_data_i     (wr_data_i),
    .pkt_start_i   (pkt_start_i),
    .pid_i         (pid_i),
    .wr_full_o     (wr_full_o),
    .pkt_end_o     (pkt_end_o),
    .line_o        (line_o)
  );

  bind usb_tx_top usb_tx_properties i_usb_tx_properties (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wr_valid_i (wr_valid_i),
    .wr_full_o  (wr_full_o),
    .pkt_end_o  (pkt_end_o),
    .line_o     (line_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Packet end pulses, sampled mid-cycle
  always @(negedge clk_i) begin
    if (pkt_end_o) begin
      end_pulses <= end_pulses + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Run limit
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
      print_summary();
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic print_summary();
    $display("Checks: %0d, check errors: %0d, property failures: %0d", checks, errors,
             i_usb_tx_top.i_usb_tx_properties.fail_cnt);
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic confirm(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      $display("Check failed at %0t ns: %s", $time, what);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and line capture
  ////////////////////////////////////////////////////////////////////////////

  task automatic set_pinflip(input logic flip);
    @(posedge clk_i);
    cfg_pinflip_i <= flip;
    repeat (2) @(posedge clk_i);
  endtask

  // Released bus rests in J, swapped by pin flip
  task automatic verify_idle();
    @(negedge clk_i);
    compare_value("line_o.oe", line_o.oe, 0);
    compare_value("line_o.se0", line_o.se0, 0);
    compare_value("line_o.dp", line_o.dp, !cfg_pinflip_i);
    compare_value("line_o.dn", line_o.dn, cfg_pinflip_i);
    compare_value("line_o.d", line_o.d, !cfg_pinflip_i);
  endtask

  task automatic write_payload(input int base, input int count);
    for (int i = 0; i < count; i++) begin
      @(posedge clk_i);
      wr_valid_i <= 1'b1;
      wr_data_i  <= stim_mem[base + i];
    end
    @(posedge clk_i);
    wr_valid_i <= 1'b0;
  endtask

  task automatic start_packet(input usb_pid_t pid);
    @(posedge clk_i);
    pkt_start_i <= 1'b1;
    pid_i       <= pid;
    @(posedge clk_i);
    pkt_start_i <= 1'b0;
  endtask

  // One symbol per bit time from the rise of oe until it falls
  task automatic capture_line();
    usb_line_t held;
    symbols.delete();
    do begin
      @(negedge clk_i);
    end while (!line_o.oe);
    while (line_o.oe) begin
      held = line_o;
      confirm(line_o.se0 || (line_o.dp != line_o.dn), "dp and dn not complementary");
      if (line_o.se0) begin
        symbols.push_back(SYM_SE0);
      end else if (line_o.dp ^ cfg_pinflip_i) begin
        symbols.push_back(SYM_J);
      end else begin
        symbols.push_back(SYM_K);
      end
      repeat (CLKS_PER_BIT - 1) begin
        @(negedge clk_i);
        confirm(line_o == held, "line state changed within a bit time");
      end
      @(negedge clk_i);
    end
  endtask

  // NRZI decode from J, unstuff, pack LSB first, then check the EOP
  task automatic decode_symbols();
    logic [1:0] prev;
    logic       bit_val;
    usb_byte_t  acc;
    int         ones;
    int         nbits;
    int         k;
    got_bytes.delete();
    prev  = SYM_J;
    acc   = '0;
    ones  = 0;
    nbits = 0;
    k     = 0;
    while (k < symbols.size() && symbols[k] != SYM_SE0) begin
      bit_val = (symbols[k] == prev);
      prev    = symbols[k];
      k++;
      if (ones == STUFF_RUN) begin
        confirm(!bit_val, "stuffed zero missing after six ones");
        ones = 0;
      end else begin
        ones = bit_val ? ones + 1 : 0;
        acc  = {bit_val, acc[7:1]};
        nbits++;
        if (nbits % 8 == 0) begin
          got_bytes.push_back(acc);
        end
      end
    end
    confirm(nbits % 8 == 0, "packet is not a whole number of bytes");
    confirm(symbols.size() == k + 3, "end of packet is not three bit times long");
    if (symbols.size() == k + 3) begin
      compare_value("line_o EOP bit 1", symbols[k + 1], SYM_SE0);
      compare_value("line_o EOP bit 2", symbols[k + 2], SYM_J);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test cases
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_packet(input logic flip, input usb_pid_t pid, input int base,
                             input int count);
    usb_byte_t exp_bytes [$];
    int        ends_before;
    set_pinflip(flip);
    verify_idle();
    write_payload(base, count);
    ends_before = end_pulses;
    start_packet(pid);
    capture_line();
    decode_symbols();
    exp_bytes.push_back(SYNC_PATTERN);
    exp_bytes.push_back({~pid, pid});
    if (pid[1:0] == DATA_PID_BITS) begin
      for (int i = 0; i < count + 2; i++) begin
        exp_bytes.push_back(stim_mem[base + i]);
      end
    end
    compare_value("line_o byte count", got_bytes.size(), exp_bytes.size());
    for (int i = 0; i < exp_bytes.size() && i < got_bytes.size(); i++) begin
      compare_value($sformatf("line_o byte %0d", i), got_bytes[i], exp_bytes[i]);
    end
    compare_value("pkt_end_o pulses", end_pulses - ends_before, 1);
    verify_idle();
  endtask

  // Constant J/K toggling while the test mode is held
  task automatic exercise_osc_test();
    int ends_before;
    set_pinflip(1'b0);
    ends_before = end_pulses;
    @(posedge clk_i);
    osc_test_i <= 1'b1;
    do begin
      @(negedge clk_i);
    end while (!line_o.oe);
    for (int i = 0; i < OSC_BITS; i++) begin
      compare_value("line_o.oe", line_o.oe, 1);
      compare_value("line_o.se0", line_o.se0, 0);
      // First bit leaves J for K, then J and K take turns
      compare_value($sformatf("line_o.dp bit %0d", i), line_o.dp ^ cfg_pinflip_i, i % 2);
      repeat (CLKS_PER_BIT) @(negedge clk_i);
    end
    @(posedge clk_i);
    osc_test_i <= 1'b0;
    do begin
      @(negedge clk_i);
    end while (line_o.oe);
    verify_idle();
    compare_value("pkt_end_o pulses", end_pulses - ends_before, 0);
  endtask

  // Link reset in the middle of the PID byte with a full buffer
  task automatic interrupt_with_link_reset(input usb_pid_t pid, input int base,
                                           input int count);
    int ends_before;
    set_pinflip(1'b0);
    write_payload(base, count);
    @(negedge clk_i);
    compare_value("wr_full_o", wr_full_o, count >= FIFO_DEPTH);
    ends_before = end_pulses;
    start_packet(pid);
    do begin
      @(negedge clk_i);
    end while (!line_o.oe);
    repeat (12 * CLKS_PER_BIT) @(posedge clk_i);
    link_reset_i <= 1'b1;
    @(posedge clk_i);
    link_reset_i <= 1'b0;
    verify_idle();
    compare_value("wr_full_o", wr_full_o, 0);
    repeat (16 * CLKS_PER_BIT) @(negedge clk_i);
    compare_value("line_o.oe", line_o.oe, 0);
    compare_value("pkt_end_o pulses", end_pulses - ends_before, 0);
  endtask

  initial begin
    int        ptr;
    int        bits;
    logic [7:0] mode;
    usb_pid_t  pid;
    int        count;
    rst_ni        = 1'b0;
    link_reset_i  = 1'b0;
    cfg_pinflip_i = 1'b0;
    osc_test_i    = 1'b0;
    wr_valid_i    = 1'b0;
    wr_data_i     = '0;
    pkt_start_i   = 1'b0;
    pid_i         = '0;
    $readmemh("testbench/tx_input.txt", stim_mem);

    // Limit from packet bit times with room for stuffing and gaps
    cycle_limit = MARGIN;
    ptr = 0;
    while (ptr + 5 <= MEM_SIZE && stim_mem[ptr] !== LIST_END && !$isunknown(stim_mem[ptr])) begin
      bits = (stim_mem[ptr + 2] + 4) * 8;
      cycle_limit += (bits + bits / STUFF_RUN + 16) * CLKS_PER_BIT + stim_mem[ptr + 2] + 40;
      if (stim_mem[ptr] == MODE_OSC) begin
        cycle_limit += (OSC_BITS + 32) * CLKS_PER_BIT;
      end
      ptr += stim_mem[ptr + 2] + 5;
    end

    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    verify_idle();

    ptr = 0;
    while (ptr + 5 <= MEM_SIZE && stim_mem[ptr] !== LIST_END && !$isunknown(stim_mem[ptr])) begin
      mode  = stim_mem[ptr];
      pid   = stim_mem[ptr + 1][3:0];
      count = stim_mem[ptr + 2];
      case (mode)
        MODE_OSC:  exercise_osc_test();
        MODE_LINK: interrupt_with_link_reset(pid, ptr + 3, count);
        default:   send_packet(mode == MODE_FLIP, pid, ptr + 3, count);
      endcase
      ptr += count + 5;
      repeat (4 + ($random(seed) & 15)) @(posedge clk_i);
    end

    print_summary();
    if (errors == 0 && i_usb_tx_top.i_usb_tx_properties.fail_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* testbench/usb_tx_properties.sv */
/*
  Bus and stimulus properties of the transmit top level
*/
`timescale 1ns/100ps

module usb_tx_properties
  import usb_pkg::*;
(
  input logic      clk_i,
  input logic      rst_ni,
  input logic      wr_valid_i,
  input logic      wr_full_o,
  input logic      pkt_end_o,
  input usb_line_t line_o
);

  int fail_cnt = 0;

  // D+ and D- never drive high together
  a_not_both_high: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(line_o.dp && line_o.dn))
    else begin
      $error("dp and dn both high");
      fail_cnt++;
    end

  a_se0_low: assert property (@(posedge clk_i) disable iff (!rst_ni)
    line_o.se0 |-> (!line_o.dp && !line_o.dn))
    else begin
      $error("se0 set while dp or dn is high");
      fail_cnt++;
    end

  // Stimulus error, the buffer drops such a write
  a_no_write_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_full_o |-> !wr_valid_i)
    else begin
      $error("write while the buffer is full");
      fail_cnt++;
    end

  a_end_driven: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pkt_end_o |-> line_o.oe)
    else begin
      $error("packet end pulse while the bus is released");
      fail_cnt++;
    end

endmodule

/* verilog/usb_tx_top.sv */
/*
  USB full-speed transmit subsystem: bit timer, transmit buffer and
  packet serializer
*/
`timescale 1ns/100ps

module usb_tx_top
  import usb_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      link_reset_i,
  input  logic      cfg_pinflip_i,
  input  logic      osc_test_i,
  input  logic      wr_valid_i,
  input  usb_byte_t wr_data_i,
  input  logic      pkt_start_i,
  input  usb_pid_t  pid_i,
  output logic      wr_full_o,
  output logic      pkt_end_o,
  output usb_line_t line_o
);

  logic      bit_strobe;
  logic      tx_data_avail;
  logic      tx_data_get;
  usb_byte_t tx_data;

  // Bit pace, realigned on link reset
  usb_bit_timer i_usb_bit_timer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .link_reset_i (link_reset_i),
    .bit_strobe_o (bit_strobe)
  );

  // Payload bytes from the host
  usb_tx_fifo i_usb_tx_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .link_reset_i (link_reset_i),
    .wr_valid_i   (wr_valid_i),
    .wr_data_i    (wr_data_i),
    .rd_get_i     (tx_data_get),
    .rd_avail_o   (tx_data_avail),
    .rd_data_o    (tx_data),
    .full_o       (wr_full_o)
  );

  usb_fs_tx i_usb_fs_tx (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .link_reset_i    (link_reset_i),
    .cfg_pinflip_i   (cfg_pinflip_i),
    .osc_test_i      (osc_test_i),
    .bit_strobe_i    (bit_strobe),
    .pkt_start_i     (pkt_start_i),
    .pid_i           (pid_i),
    .tx_data_avail_i (tx_data_avail),
    .tx_data_i       (tx_data),
    .tx_data_get_o   (tx_data_get),
    .pkt_end_o       (pkt_end_o),
    .line_o          (line_o)
  );

endmodule

/* verilog/usb_fs_tx.sv */
/*
  Full-speed packet serializer: sync, PID, payload and CRC16 with bit
  stuffing and NRZI, EOP generation, pin flip and oscillator test mode
*/
`timescale 1ns/100ps

module usb_fs_tx
  import usb_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      link_reset_i,
  input  logic      cfg_pinflip_i,
  input  logic      osc_test_i,
  input  logic      bit_strobe_i,
  input  logic      pkt_start_i,
  input  usb_pid_t  pid_i,
  input  logic      tx_data_avail_i,
  input  usb_byte_t tx_data_i,
  output logic      tx_data_get_o,
  output logic      pkt_end_o,
  output usb_line_t line_o
);

  typedef enum logic [2:0] {Idle, Sync, Pid, DataOrCrc0, Crc1, Eop, OscTest} state_e;
  typedef enum logic [1:0] {OsIdle, OsWaitByte, OsTransmit} out_state_e;

  // Idle J with the bus released
  localparam usb_line_t LINE_RESET = '{oe: 1'b0, d: 1'b1, se0: 1'b0, dp: 1'b1, dn: 1'b0};

  state_e               state_q, state_d;
  out_state_e           out_state_q, out_state_d;
  usb_pid_t             pid_q;
  usb_byte_t            data_sr_q, data_sr_d;
  logic [7:0]           oe_sr_q, oe_sr_d;
  logic [7:0]           se0_sr_q, se0_sr_d;
  logic                 payload_q, payload_d;
  logic                 get_q, get_d;
  logic                 byte_strobe_q, byte_strobe_d;
  logic [2:0]           bit_cnt_q, bit_cnt_d;
  logic [STUFF_RUN-2:0] hist_q, hist_d;
  logic [STUFF_RUN-1:0] hist;
  logic                 bitstuff;
  logic                 stuffed_q;
  usb_crc16_t           crc_q, crc_d;
  usb_byte_t            crc_byte0, crc_byte1;
  logic                 crc_fb;
  logic                 test_start;
  logic                 ser_data, ser_oe, ser_se0;
  logic                 nrzi_en;
  logic                 nrzi_q, nrzi_d;
  logic                 oe_d, se0_d;
  logic [2:0]           eop_q, eop_d;
  usb_line_t            line_q, line_d, line_idle;

  // PID is captured with the start pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pid_q <= '0;
    end else if (link_reset_i) begin
      pid_q <= '0;
    end else if (pkt_start_i) begin
      pid_q <= pid_i;
    end
  end

  assign ser_data = data_sr_q[0];
  assign ser_oe   = oe_sr_q[0];
  assign ser_se0  = se0_sr_q[0];

  // Current bit plus the ones before it
  assign hist     = {ser_data, hist_q};
  assign bitstuff = &hist;

  // Third EOP bit, the final J
  assign pkt_end_o = bit_strobe_i && (se0_sr_q[1:0] == 2'b01);

  // Remainder inverted, high bit first on the wire
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      crc_byte0[i] = ~crc_q[15 - i];
      crc_byte1[i] = ~crc_q[7 - i];
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Packet FSM and shift registers
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    data_sr_d  = data_sr_q;
    oe_sr_d    = oe_sr_q;
    se0_sr_d   = se0_sr_q;
    payload_d  = payload_q;
    get_d      = 1'b0;
    hist_d     = hist_q;
    bit_cnt_d  = bit_cnt_q;
    test_start = 1'b0;

    unique case (state_q)
      Idle: begin
        if (osc_test_i) begin
          state_d    = OscTest;
          test_start = 1'b1;
        end else if (pkt_start_i) begin
          state_d = Sync;
        end
      end
      Sync: begin
        if (byte_strobe_q) begin
          state_d   = Pid;
          data_sr_d = SYNC_BYTE;
          oe_sr_d   = 8'hFF;
          se0_sr_d  = 8'h00;
        end
      end
      Pid: begin
        if (byte_strobe_q) begin
          // Tokens and handshakes go straight to EOP
          state_d   = (pid_q[1:0] == PID_DATA_TYPE) ? DataOrCrc0 : Eop;
          data_sr_d = {~pid_q, pid_q};
          oe_sr_d   = 8'hFF;
          se0_sr_d  = 8'h00;
        end
      end
      DataOrCrc0: begin
        if (byte_strobe_q) begin
          oe_sr_d  = 8'hFF;
          se0_sr_d = 8'h00;
          if (tx_data_avail_i) begin
            payload_d = 1'b1;
            get_d     = 1'b1;
            data_sr_d = tx_data_i;
          end else begin
            // Empty buffer closes the payload
            state_d   = Crc1;
            payload_d = 1'b0;
            data_sr_d = crc_byte0;
          end
        end
      end
      Crc1: begin
        if (byte_strobe_q) begin
          state_d   = Eop;
          data_sr_d = crc_byte1;
          oe_sr_d   = 8'hFF;
          se0_sr_d  = 8'h00;
        end
      end
      Eop: begin
        if (byte_strobe_q) begin
          // SE0, SE0, J then release
          state_d   = Idle;
          data_sr_d = '0;
          oe_sr_d   = 8'b0000_0111;
          se0_sr_d  = 8'b0000_0111;
        end
      end
      OscTest: begin
        if (byte_strobe_q) begin
          if (!osc_test_i) begin
            state_d = Idle;
            oe_sr_d = 8'h00;
          end else begin
            // All zeros toggle the line every bit
            data_sr_d = 8'h00;
            oe_sr_d   = 8'hFF;
            se0_sr_d  = 8'h00;
          end
        end
      end
      default: state_d = Idle;
    endcase

    // One idle bit time ahead of sync
    if (pkt_start_i) begin
      bit_cnt_d = 3'd7;
      hist_d    = '0;
    end else if (bit_strobe_i) begin
      hist_d = hist[STUFF_RUN-1:1];
      if (bitstuff) begin
        // Hold the byte and send a zero next
        data_sr_d[0] = 1'b0;
      end else begin
        bit_cnt_d = bit_cnt_q + 1'b1;
        data_sr_d = data_sr_q >> 1;
        oe_sr_d   = oe_sr_q >> 1;
        se0_sr_d  = se0_sr_q >> 1;
      end
    end
  end

  assign byte_strobe_d = bit_strobe_i && !bitstuff && !pkt_start_i && (bit_cnt_q == 3'd0);

  // CRC16 over payload bits, stuffed zeros skipped
  assign crc_fb = ser_data ^ crc_q[15];

  always_comb begin
    crc_d = crc_q;
    if (pkt_start_i) begin
      crc_d = CRC16_INIT;
    end else if (bit_strobe_i && payload_q && !stuffed_q) begin
      crc_d = {crc_q[14:0], 1'b0} ^ ({16{crc_fb}} & CRC16_POLY);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= Idle;
      data_sr_q     <= '0;
      oe_sr_q       <= '0;
      se0_sr_q      <= '0;
      payload_q     <= 1'b0;
      get_q         <= 1'b0;
      byte_strobe_q <= 1'b0;
      hist_q        <= '0;
      bit_cnt_q     <= '0;
      stuffed_q     <= 1'b0;
      crc_q         <= CRC16_INIT;
    end else if (link_reset_i) begin
      state_q       <= Idle;
      data_sr_q     <= '0;
      oe_sr_q       <= '0;
      se0_sr_q      <= '0;
      payload_q     <= 1'b0;
      get_q         <= 1'b0;
      byte_strobe_q <= 1'b0;
      hist_q        <= '0;
      bit_cnt_q     <= '0;
      stuffed_q     <= 1'b0;
      crc_q         <= CRC16_INIT;
    end else begin
      state_q       <= state_d;
      data_sr_q     <= data_sr_d;
      oe_sr_q       <= oe_sr_d;
      se0_sr_q      <= se0_sr_d;
      payload_q     <= payload_d;
      get_q         <= get_d;
      byte_strobe_q <= byte_strobe_d;
      hist_q        <= hist_d;
      bit_cnt_q     <= bit_cnt_d;
      crc_q         <= crc_d;
      // Marks the bit on the line as a stuffed zero
      if (pkt_start_i) begin
        stuffed_q <= 1'b0;
      end else if (bit_strobe_i) begin
        stuffed_q <= bitstuff;
      end
    end
  end

  assign tx_data_get_o = get_q;

  //////////////////////////////////////////////////////////////////////////
  // NRZI coding and bus drive
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    out_state_d = out_state_q;
    nrzi_en     = 1'b0;
    unique case (out_state_q)
      OsIdle: begin
        if (pkt_start_i || test_start) begin
          out_state_d = OsWaitByte;
        end
      end
      OsWaitByte: begin
        if (byte_strobe_q) begin
          out_state_d = OsTransmit;
        end
      end
      OsTransmit: begin
        nrzi_en = 1'b1;
        if (bit_strobe_i && !ser_oe) begin
          out_state_d = OsIdle;
        end
      end
      default: out_state_d = OsIdle;
    endcase
  end

  always_comb begin
    nrzi_d = nrzi_q;
    oe_d   = line_q.oe;
    se0_d  = line_q.se0;
    eop_d  = eop_q;
    if (pkt_start_i) begin
      // Start from J so sync opens with K
      nrzi_d = 1'b1;
      eop_d  = 3'b100;
    end else if (bit_strobe_i && nrzi_en) begin
      oe_d = ser_oe;
      if (ser_se0) begin
        eop_d = eop_q >> 1;
        if (eop_q[0]) begin
          nrzi_d = 1'b1;
          se0_d  = 1'b0;
        end else begin
          se0_d = 1'b1;
        end
      end else if (!ser_data) begin
        nrzi_d = ~nrzi_q;
      end
      // Released bus rests in J
      if (!oe_d) begin
        nrzi_d = 1'b1;
      end
    end
  end

  always_comb begin
    line_d.oe  = oe_d;
    line_d.se0 = se0_d;
    line_d.dp  = (nrzi_d ^ cfg_pinflip_i) & ~se0_d;
    line_d.dn  = (~nrzi_d ^ cfg_pinflip_i) & ~se0_d;
    line_d.d   = line_d.dp;
  end

  always_comb begin
    line_idle.oe  = 1'b0;
    line_idle.se0 = 1'b0;
    line_idle.dp  = ~cfg_pinflip_i;
    line_idle.dn  = cfg_pinflip_i;
    line_idle.d   = ~cfg_pinflip_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_state_q <= OsIdle;
      nrzi_q      <= 1'b1;
      eop_q       <= '0;
      line_q      <= LINE_RESET;
    end else if (link_reset_i) begin
      out_state_q <= OsIdle;
      nrzi_q      <= 1'b1;
      eop_q       <= '0;
      line_q      <= line_idle;
    end else begin
      out_state_q <= out_state_d;
      nrzi_q      <= nrzi_d;
      eop_q       <= eop_d;
      line_q      <= line_d;
    end
  end

  assign line_o = line_q;

endmodule

/* verilog/usb_tx_fifo.sv */
/*
  Transmit byte buffer: circular storage between the host write strobe
  and the serializer get pulse, flushed by link reset
*/
`timescale 1ns/100ps

module usb_tx_fifo
  import usb_pkg::*;
  import usb_tx_cfg_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      link_reset_i,
  input  logic      wr_valid_i,
  input  usb_byte_t wr_data_i,
  input  logic      rd_get_i,
  output logic      rd_avail_o,
  output usb_byte_t rd_data_o,
  output logic      full_o
);

  localparam fifo_ptr_t LAST_PTR = fifo_ptr_t'(FIFO_DEPTH - 1);
  localparam fifo_cnt_t FULL_CNT = fifo_cnt_t'(FIFO_DEPTH);

  usb_byte_t mem_q [FIFO_DEPTH];
  fifo_ptr_t wr_ptr_q;
  fifo_ptr_t rd_ptr_q;
  fifo_cnt_t cnt_q;
  logic      push;
  logic      pop;

  assign full_o     = (cnt_q == FULL_CNT);
  assign rd_avail_o = (cnt_q != '0);

  // Writes into a full buffer are dropped
  assign push = wr_valid_i && !full_o;
  assign pop  = rd_get_i && rd_avail_o;

  // Byte storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (link_reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
      end
      // Occupancy only moves when exactly one side is active
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Oldest byte, next one shows the clock after a pop
  assign rd_data_o = mem_q[rd_ptr_q];

endmodule

/* verilog/usb_bit_timer.sv */
/*
  Free-running bit timer, one strobe per full-speed bit time
*/
`timescale 1ns/100ps

module usb_bit_timer
  import usb_tx_cfg_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic link_reset_i,
  output logic bit_strobe_o
);

  localparam bit_cnt_t LAST_CNT = bit_cnt_t'(CLKS_PER_BIT - 1);

  bit_cnt_t cnt_q;

  // Link reset restarts the phase so the first strobe lands 4 clocks later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (link_reset_i) begin
      cnt_q <= '0;
    end else if (cnt_q == LAST_CNT) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Strobe in the last clock of each bit
  assign bit_strobe_o = (cnt_q == LAST_CNT);

endmodule

/* verilog/usb_tx_cfg_pkg.sv */
/*
  Implementation constants of the transmit subsystem: bit timing at
  48 MHz, buffer depth and the counter types derived from them
*/
package usb_tx_cfg_pkg;

  // 48 MHz system clock over 12 Mb/s full speed
  localparam int unsigned CLKS_PER_BIT = 4;

  // Transmit buffer size in bytes
  localparam int unsigned FIFO_DEPTH = 16;

  localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int unsigned BIT_CNT_W  = $clog2(CLKS_PER_BIT);

  typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
  typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;
  typedef logic [BIT_CNT_W-1:0]  bit_cnt_t;

endpackage

/* verilog/usb_pkg.sv */
/*
  USB protocol definitions: PID, byte and CRC16 types, the line-state
  struct driven to the transceiver and the fixed bit patterns of a packet
*/
package usb_pkg;

  typedef logic [3:0]  usb_pid_t;
  typedef logic [7:0]  usb_byte_t;
  typedef logic [15:0] usb_crc16_t;

  // Line state towards the transceiver, d mirrors D+
  typedef struct packed {
    logic oe;
    logic d;
    logic se0;
    logic dp;
    logic dn;
  } usb_line_t;

  // DATA0, DATA1, DATA2 and MDATA all end in these two bits
  localparam logic [1:0] PID_DATA_TYPE = 2'b11;

  // CRC16 x^16 + x^15 + x^2 + 1
  localparam usb_crc16_t CRC16_POLY = 16'h8005;
  localparam usb_crc16_t CRC16_INIT = 16'hFFFF;

  // Seven zeros then a one, sent LSB first
  localparam usb_byte_t SYNC_BYTE = 8'b1000_0000;

  // Ones in a row before a zero is stuffed
  localparam int unsigned STUFF_RUN = 6;

endpackage
